//--- common/job_regs_pkg.sv
// Job controller register definitions
package job_regs_pkg;

  // Bus and storage geometry
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned BE_W      = DATA_W / 8;
  localparam int unsigned N_CONTEXT = 2;
  localparam int unsigned CXT_W     = 1;
  localparam int unsigned REG_IDX_W = 5;
  localparam int unsigned ADDR_W    = REG_IDX_W + CXT_W;  // Context field sits above index

  // Parameter registers, one bank per context
  localparam int unsigned N_IO_REGS = 4;
  localparam int unsigned IO_IDX_W  = $clog2(N_IO_REGS);
  localparam int unsigned IO_BASE   = 8;                   // Index of first parameter word

  localparam int unsigned JOB_ID_W  = 8;

  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [BE_W-1:0]       be_t;
  typedef logic [CXT_W-1:0]      cxt_t;
  typedef logic [IO_IDX_W-1:0]   io_idx_t;
  typedef logic [JOB_ID_W-1:0]   job_id_t;
  typedef word_t [N_IO_REGS-1:0] params_t;

  // Mandatory register indexes
  localparam logic [REG_IDX_W-1:0] REG_TRIGGER   = REG_IDX_W'(0);
  localparam logic [REG_IDX_W-1:0] REG_ACQUIRE   = REG_IDX_W'(1);
  localparam logic [REG_IDX_W-1:0] REG_FINISHED  = REG_IDX_W'(2);
  localparam logic [REG_IDX_W-1:0] REG_STATUS    = REG_IDX_W'(3);
  localparam logic [REG_IDX_W-1:0] REG_RUNNING   = REG_IDX_W'(4);
  localparam logic [REG_IDX_W-1:0] REG_SOFTCLEAR = REG_IDX_W'(5);

  // Response codes
  localparam word_t RESP_ALL_CXT_BUSY = '1;               // Acquire with no free context
  localparam word_t RESP_UNKNOWN      = 32'hDEAD_BEEF;    // Unmapped mandatory index

endpackage

//--- regfile/req_decode.sv
// Request decode stage
`timescale 1ns/10ps

module req_decode (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_i,
  input  logic                               wr_i,
  input  logic [job_regs_pkg::ADDR_W-1:0]    addr_i,
  input  job_regs_pkg::word_t                wdata_i,
  input  job_regs_pkg::be_t                  be_i,
  output logic                               valid_o,
  output logic                               wr_o,
  output logic                               mand_o,
  output logic [job_regs_pkg::REG_IDX_W-1:0] idx_o,
  output job_regs_pkg::io_idx_t              io_o,
  output job_regs_pkg::cxt_t                 cxt_o,
  output job_regs_pkg::word_t                wdata_o,
  output job_regs_pkg::be_t                  be_o
);

  logic [job_regs_pkg::REG_IDX_W-1:0] idx_d;
  job_regs_pkg::cxt_t                 cxt_d;
  logic [31:0]                        idx_ext;   // Index widened for range checks
  logic [31:0]                        io_off;
  logic                               is_io;
  job_regs_pkg::io_idx_t              io_d;

  // Address fields
  assign idx_d = addr_i[job_regs_pkg::REG_IDX_W-1:0];
  assign cxt_d = addr_i[job_regs_pkg::ADDR_W-1:job_regs_pkg::REG_IDX_W];

  // Parameter window is IO_BASE up to IO_BASE+N_IO_REGS-1
  always_comb begin
    idx_ext = 32'(idx_d);
    io_off  = idx_ext - job_regs_pkg::IO_BASE;
    is_io   = (idx_ext >= job_regs_pkg::IO_BASE) &&
              (idx_ext < job_regs_pkg::IO_BASE + job_regs_pkg::N_IO_REGS);
    io_d    = io_off[job_regs_pkg::IO_IDX_W-1:0];
  end

  // Control fields of the stage register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
      wr_o    <= 1'b0;
      mand_o  <= 1'b0;
    end else begin
      valid_o <= req_i;
      if (req_i) begin
        wr_o   <= wr_i;
        mand_o <= ~is_io;  // Indexes past the window fall back to mandatory decode
      end
    end
  end

  // Payload only moves with a request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      idx_o   <= idx_d;
      io_o    <= io_d;
      cxt_o   <= cxt_d;
      wdata_o <= wdata_i;
      be_o    <= be_i;
    end
  end

endmodule

//--- regfile/job_tracker.sv
// Job id and context tracker
`timescale 1ns/10ps

module job_tracker (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               valid_i,
  input  logic                               wr_i,
  input  logic                               mand_i,
  input  logic [job_regs_pkg::REG_IDX_W-1:0] idx_i,
  input  job_regs_pkg::word_t                wdata_i,
  input  logic                               done_i,
  output job_regs_pkg::word_t                rdata_o,
  output logic                               busy_o,
  output job_regs_pkg::cxt_t                 run_cxt_o
);

  // Contexts are used as a ring
  function automatic job_regs_pkg::cxt_t next_cxt(job_regs_pkg::cxt_t c);
    if (c == job_regs_pkg::cxt_t'(job_regs_pkg::N_CONTEXT - 1)) begin
      return '0;
    end
    return c + 1'b1;
  endfunction

  logic                                 mand_rd;
  logic                                 mand_wr;
  logic                                 acquire;
  logic                                 trigger;
  logic                                 softclear;
  logic                                 fin_access;
  logic                                 full;
  logic                                 true_done;

  logic [job_regs_pkg::N_CONTEXT-1:0]   busy_q;
  job_regs_pkg::cxt_t                   ptr_cxt_q;   // Next context to be queued
  job_regs_pkg::cxt_t                   run_cxt_q;   // Context owned by the engine
  job_regs_pkg::job_id_t                offload_id_q;
  job_regs_pkg::job_id_t                running_id_q;
  logic                                 run_incr_q;
  logic [1:0]                           fin_cnt_q;

  job_regs_pkg::word_t                  status_word;
  job_regs_pkg::word_t                  rdata_d;
  job_regs_pkg::word_t                  rdata_q;

  assign mand_rd    = valid_i & ~wr_i & mand_i;
  assign mand_wr    = valid_i & wr_i & mand_i;
  assign acquire    = mand_rd && (idx_i == job_regs_pkg::REG_ACQUIRE);
  // A trigger write of zero queues a job
  assign trigger    = mand_wr && (idx_i == job_regs_pkg::REG_TRIGGER) && (wdata_i == '0);
  assign softclear  = mand_wr && (idx_i == job_regs_pkg::REG_SOFTCLEAR);
  assign fin_access = valid_i && mand_i && (idx_i == job_regs_pkg::REG_FINISHED);
  assign full       = &busy_q;
  assign true_done  = done_i & busy_q[run_cxt_q];   // Spurious done is dropped

  // Context occupancy and pointers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= '0;
      ptr_cxt_q <= '0;
      run_cxt_q <= '0;
    end else if (softclear) begin
      busy_q    <= '0;
      ptr_cxt_q <= '0;
      run_cxt_q <= '0;
    end else begin
      if (true_done) begin
        busy_q[run_cxt_q] <= 1'b0;
        run_cxt_q         <= next_cxt(run_cxt_q);
      end
      if (trigger && !full) begin
        busy_q[ptr_cxt_q] <= 1'b1;
        ptr_cxt_q         <= next_cxt(ptr_cxt_q);
      end
    end
  end

  // Job id counters, the running id trails done by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_id_q <= '0;
      running_id_q <= '0;
      run_incr_q   <= 1'b0;
    end else if (softclear) begin
      offload_id_q <= '0;
      running_id_q <= '0;
      run_incr_q   <= 1'b0;
    end else begin
      run_incr_q <= true_done;
      if (acquire && !full) begin
        offload_id_q <= offload_id_q + 1'b1;
      end
      if (run_incr_q) begin
        running_id_q <= running_id_q + 1'b1;
      end
    end
  end

  // Finished jobs, saturating at two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fin_cnt_q <= '0;
    end else if (softclear || fin_access) begin
      fin_cnt_q <= '0;
    end else if (true_done && (fin_cnt_q != 2'd2)) begin
      fin_cnt_q <= fin_cnt_q + 1'b1;
    end
  end

  // One status byte per context
  always_comb begin
    status_word = '0;
    for (int i = 0; i < job_regs_pkg::N_CONTEXT; i++) begin
      status_word[8*i] = busy_q[i];
    end
  end

  always_comb begin
    rdata_d = '0;
    case (idx_i)
      job_regs_pkg::REG_ACQUIRE: begin
        if (full) begin
          rdata_d = job_regs_pkg::RESP_ALL_CXT_BUSY;
        end else begin
          rdata_d[job_regs_pkg::JOB_ID_W-1:0] = offload_id_q;
        end
      end
      job_regs_pkg::REG_FINISHED:  rdata_d[1:0] = fin_cnt_q;
      job_regs_pkg::REG_STATUS:    rdata_d = status_word;
      job_regs_pkg::REG_RUNNING:   rdata_d[job_regs_pkg::JOB_ID_W-1:0] = running_id_q;
      job_regs_pkg::REG_SOFTCLEAR: rdata_d = '0;
      default:                     rdata_d = job_regs_pkg::RESP_UNKNOWN;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (mand_rd) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o   = rdata_q;
  assign busy_o    = busy_q[run_cxt_q];
  assign run_cxt_o = run_cxt_q;

endmodule

//--- regfile/param_store.sv
// Per-context parameter registers
`timescale 1ns/10ps

module param_store (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   valid_i,
  input  logic                   wr_i,
  input  logic                   mand_i,
  input  job_regs_pkg::io_idx_t  io_i,
  input  job_regs_pkg::cxt_t     cxt_i,
  input  job_regs_pkg::word_t    wdata_i,
  input  job_regs_pkg::be_t      be_i,
  input  job_regs_pkg::cxt_t     run_cxt_i,
  output job_regs_pkg::word_t    rdata_o,
  output job_regs_pkg::params_t  params_o
);

  // One parameter bank per context
  job_regs_pkg::params_t [job_regs_pkg::N_CONTEXT-1:0] mem_q;
  job_regs_pkg::word_t                                 rdata_q;

  logic                                                io_wr;
  logic                                                io_rd;

  assign io_wr = valid_i & wr_i & ~mand_i;
  assign io_rd = valid_i & ~wr_i & ~mand_i;

  // Byte-enabled write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (io_wr) begin
      for (int b = 0; b < job_regs_pkg::BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[cxt_i][io_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Registered read of the addressed word
  always_ff @(posedge clk_i) begin
    if (io_rd) begin
      rdata_q <= mem_q[cxt_i][io_i];
    end
  end

  assign rdata_o  = rdata_q;
  assign params_o = mem_q[run_cxt_i];  // Engine sees the running context

endmodule

//--- regfile/ctrl_regfile_top.sv
// Job controller register file
`timescale 1ns/10ps

module ctrl_regfile_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Bus side
  input  logic                             req_i,
  input  logic                             wr_i,
  input  logic [job_regs_pkg::ADDR_W-1:0]  addr_i,
  input  job_regs_pkg::word_t              wdata_i,
  input  job_regs_pkg::be_t                be_i,
  output job_regs_pkg::word_t              rdata_o,
  output logic                             rvalid_o,
  // Engine side
  input  logic                             done_i,
  output logic                             busy_o,
  output job_regs_pkg::cxt_t               run_cxt_o,
  output job_regs_pkg::params_t            params_o
);

  // Decoded request, stage 1 to stage 2
  logic                                d_valid;
  logic                                d_wr;
  logic                                d_mand;
  logic [job_regs_pkg::REG_IDX_W-1:0]  d_idx;
  job_regs_pkg::io_idx_t               d_io;
  job_regs_pkg::cxt_t                  d_cxt;
  job_regs_pkg::word_t                 d_wdata;
  job_regs_pkg::be_t                   d_be;

  job_regs_pkg::cxt_t                  run_cxt;
  job_regs_pkg::word_t                 trk_rdata;
  job_regs_pkg::word_t                 par_rdata;

  logic                                rvalid_q;
  logic                                rd_mand_q;  // Which stage 2 block owns the read word

  req_decode u_req_decode (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .wr_i    (wr_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .valid_o (d_valid),
    .wr_o    (d_wr),
    .mand_o  (d_mand),
    .idx_o   (d_idx),
    .io_o    (d_io),
    .cxt_o   (d_cxt),
    .wdata_o (d_wdata),
    .be_o    (d_be)
  );

  job_tracker u_job_tracker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (d_valid),
    .wr_i      (d_wr),
    .mand_i    (d_mand),
    .idx_i     (d_idx),
    .wdata_i   (d_wdata),
    .done_i    (done_i),
    .rdata_o   (trk_rdata),
    .busy_o    (busy_o),
    .run_cxt_o (run_cxt)
  );

  param_store u_param_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (d_valid),
    .wr_i      (d_wr),
    .mand_i    (d_mand),
    .io_i      (d_io),
    .cxt_i     (d_cxt),
    .wdata_i   (d_wdata),
    .be_i      (d_be),
    .run_cxt_i (run_cxt),
    .rdata_o   (par_rdata),
    .params_o  (params_o)
  );

  // Track the read through stage 2
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q  <= 1'b0;
      rd_mand_q <= 1'b0;
    end else begin
      rvalid_q  <= d_valid & ~d_wr;
      rd_mand_q <= d_mand;
    end
  end

  assign rdata_o   = rd_mand_q ? trk_rdata : par_rdata;
  assign rvalid_o  = rvalid_q;
  assign run_cxt_o = run_cxt;

endmodule

//--- verification/ctrl_regfile_sva.sv
// Register file assertions
`timescale 1ns/10ps

module ctrl_regfile_sva (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               req_i,
  input logic               wr_i,
  input logic               rvalid_o,
  input logic               done_i,
  input logic               busy_o,
  input job_regs_pkg::cxt_t run_cxt_o
);

  logic rd_req;

  assign rd_req = req_i & ~wr_i;

  // Read word comes back two edges after the request is sampled
  read_latency_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rd_req, 2) |-> rvalid_o)
    else $error("Read request without response two cycles later");

  no_spurious_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> $past(rd_req, 2))
    else $error("Read response without a matching request");

  // Completion of a busy context hands the engine to the next one
  done_advances_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (done_i && busy_o) |=> (run_cxt_o != $past(run_cxt_o)))
    else $error("Running context did not advance on completion");

  idle_done_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (done_i && !busy_o) |=> $stable(run_cxt_o))
    else $error("Running context moved on completion of an idle context");

endmodule

bind ctrl_regfile_top ctrl_regfile_sva u_ctrl_regfile_sva (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_i     (req_i),
  .wr_i      (wr_i),
  .rvalid_o  (rvalid_o),
  .done_i    (done_i),
  .busy_o    (busy_o),
  .run_cxt_o (run_cxt_o)
);

//--- verification/tb_ctrl_regfile.sv
// Register file directed testbench
`timescale 1ns/10ps

module tb_ctrl_regfile;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int RD_TIMEOUT   = 20;
  localparam int NC           = int'(job_regs_pkg::N_CONTEXT);
  localparam int NR           = int'(job_regs_pkg::N_IO_REGS);
  localparam int IDX_TRIGGER  = int'(job_regs_pkg::REG_TRIGGER);
  localparam int IDX_ACQUIRE  = int'(job_regs_pkg::REG_ACQUIRE);
  localparam int IDX_FINISHED = int'(job_regs_pkg::REG_FINISHED);
  localparam int IDX_STATUS   = int'(job_regs_pkg::REG_STATUS);
  localparam int IDX_RUNNING  = int'(job_regs_pkg::REG_RUNNING);
  localparam int IDX_SFTCLR   = int'(job_regs_pkg::REG_SOFTCLEAR);
  localparam int IDX_IO       = int'(job_regs_pkg::IO_BASE);

  typedef logic [job_regs_pkg::ADDR_W-1:0] addr_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req_i;
  logic                  wr_i;
  addr_t                 addr_i;
  job_regs_pkg::word_t   wdata_i;
  job_regs_pkg::be_t     be_i;
  logic                  done_i;
  job_regs_pkg::word_t   rdata_o;
  logic                  rvalid_o;
  logic                  busy_o;
  job_regs_pkg::cxt_t    run_cxt_o;
  job_regs_pkg::params_t params_o;

  // Reference model
  logic [31:0] par_m [NC][NR];
  logic        busy_m [NC];
  int          ptr_m;
  int          run_m;
  int          offload_m;
  int          running_m;
  int          fin_m;

  int          errors;
  int          checks;
  integer      seed;

  ctrl_regfile_top dut_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .wr_i      (wr_i),
    .addr_i    (addr_i),
    .wdata_i   (wdata_i),
    .be_i      (be_i),
    .rdata_o   (rdata_o),
    .rvalid_o  (rvalid_o),
    .done_i    (done_i),
    .busy_o    (busy_o),
    .run_cxt_o (run_cxt_o),
    .params_o  (params_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic addr_t reg_addr(input int cxt, input int idx);
    return addr_t'((cxt << job_regs_pkg::REG_IDX_W) | idx);  // Context above index
  endfunction

  // One status byte per context, 1 when busy
  function automatic logic [31:0] status_expect();
    return {23'd0, busy_m[1], 7'd0, busy_m[0]};
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got %08h, expected %08h", name, got, exp);
    end
  endtask

  task automatic bus_write(input int cxt, input int idx, input logic [31:0] data,
                           input logic [3:0] be);
    @(negedge clk_i);
    req_i   = 1'b1;
    wr_i    = 1'b1;
    addr_i  = reg_addr(cxt, idx);
    wdata_i = data;
    be_i    = be;
    @(negedge clk_i);
    req_i   = 1'b0;
    wr_i    = 1'b0;
  endtask

  task automatic bus_read(input int cxt, input int idx, output logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge clk_i);
    req_i  = 1'b1;
    wr_i   = 1'b0;
    addr_i = reg_addr(cxt, idx);
    @(negedge clk_i);
    req_i  = 1'b0;
    while (!rvalid_o && waited < RD_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!rvalid_o) begin
      errors++;
      $display("Timeout: no read response for context %0d index %0d", cxt, idx);
      data = 'x;
    end else begin
      data = rdata_o;
    end
  endtask

  task automatic read_expect(input string name, input int cxt, input int idx,
                             input logic [31:0] exp);
    logic [31:0] got;
    bus_read(cxt, idx, got);
    compare_word(name, got, exp);
  endtask

  task automatic pulse_done();
    @(negedge clk_i);
    done_i = 1'b1;
    @(negedge clk_i);
    done_i = 1'b0;
    if (busy_m[run_m]) begin  // Done with nothing running is ignored
      busy_m[run_m] = 1'b0;
      run_m         = (run_m + 1) % NC;
      running_m++;
      if (fin_m < 2) begin
        fin_m++;
      end
    end
  endtask

  task automatic queue_trigger();
    bus_write(0, IDX_TRIGGER, 32'h0, 4'hF);
    if (!(busy_m[0] && busy_m[1])) begin
      busy_m[ptr_m] = 1'b1;
      ptr_m         = (ptr_m + 1) % NC;
    end
  endtask

  task automatic acquire_expect();
    logic [31:0] exp;
    if (busy_m[0] && busy_m[1]) begin
      exp = 32'hFFFF_FFFF;
    end else begin
      exp = 32'(offload_m);
      offload_m++;
    end
    read_expect("acquire", 0, IDX_ACQUIRE, exp);
  endtask

  task automatic finished_expect();
    read_expect("finished", 0, IDX_FINISHED, 32'(fin_m));
    fin_m = 0;  // Any access clears the count
  endtask

  task automatic engine_view_check();
    compare_word("busy_o", 32'(busy_o), 32'(busy_m[run_m]));
    compare_word("run_cxt_o", 32'(run_cxt_o), 32'(run_m));
    for (int r = 0; r < NR; r++) begin
      compare_word($sformatf("params_o[%0d]", r), params_o[r], par_m[run_m][r]);
    end
  endtask

  task automatic params_readback();
    for (int c = 0; c < NC; c++) begin
      for (int r = 0; r < NR; r++) begin
        read_expect($sformatf("param[%0d][%0d]", c, r), c, IDX_IO + r, par_m[c][r]);
      end
    end
  endtask

  task automatic clear_model();
    for (int c = 0; c < NC; c++) begin
      busy_m[c] = 1'b0;
    end
    ptr_m     = 0;
    run_m     = 0;
    offload_m = 0;
    running_m = 0;
    fin_m     = 0;
  endtask

  task automatic check_reset_state();
    compare_word("rvalid_o", 32'(rvalid_o), 32'h0);
    compare_word("busy_o", 32'(busy_o), 32'h0);
    pulse_done();  // Idle engine, nothing may move
    read_expect("status", 0, IDX_STATUS, status_expect());
    read_expect("running", 0, IDX_RUNNING, 32'(running_m));
    finished_expect();
    read_expect("unmapped", 0, 6, job_regs_pkg::RESP_UNKNOWN);
    engine_view_check();
  endtask

  task automatic exercise_params();
    logic [31:0] data;
    logic [31:0] rnd;
    logic [3:0]  be;
    for (int pass = 0; pass < 2; pass++) begin
      for (int c = 0; c < NC; c++) begin
        for (int r = 0; r < NR; r++) begin
          data = $random(seed);
          rnd  = $random(seed);
          be   = rnd[3:0];
          bus_write(c, IDX_IO + r, data, be);
          for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
              par_m[c][r][8*b +: 8] = data[8*b +: 8];
            end
          end
        end
      end
    end
    params_readback();
    engine_view_check();  // Context 0 owns the engine after reset
  endtask

  task automatic acquire_and_trigger();
    acquire_expect();
    acquire_expect();
    queue_trigger();
    queue_trigger();
    read_expect("status", 0, IDX_STATUS, status_expect());
    engine_view_check();
  endtask

  task automatic full_contexts();
    acquire_expect();  // All busy, id must hold
    pulse_done();
    acquire_expect();
    engine_view_check();
  endtask

  task automatic job_completion();
    finished_expect();
    repeat (3) begin
      if (!busy_m[run_m]) begin
        queue_trigger();
      end
      pulse_done();
      read_expect("status", 0, IDX_STATUS, status_expect());
      read_expect("running", 0, IDX_RUNNING, 32'(running_m));
      engine_view_check();
    end
    finished_expect();  // Saturated at two
    finished_expect();
  endtask

  task automatic softclear_keeps_params();
    logic [31:0] data;
    queue_trigger();
    queue_trigger();
    pulse_done();  // One busy context, one finished job, engine on context 1
    acquire_expect();
    data = $random(seed);
    bus_write(0, IDX_SFTCLR, data, 4'hF);
    clear_model();
    read_expect("status", 0, IDX_STATUS, status_expect());
    read_expect("running", 0, IDX_RUNNING, 32'(running_m));
    finished_expect();
    acquire_expect();
    engine_view_check();
    params_readback();
  endtask

  initial begin
    seed    = 32'h9a1ae854;
    errors  = 0;
    checks  = 0;
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    wr_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    done_i  = 1'b0;
    clear_model();
    for (int c = 0; c < NC; c++) begin
      for (int r = 0; r < NR; r++) begin
        par_m[c][r] = 32'h0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    check_reset_state();
    exercise_params();
    acquire_and_trigger();
    full_contexts();
    job_completion();
    softclear_keeps_params();

    repeat (4) @(negedge clk_i);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
common/job_regs_pkg.sv
regfile/req_decode.sv
regfile/job_tracker.sv
regfile/param_store.sv
regfile/ctrl_regfile_top.sv
verification/ctrl_regfile_sva.sv
verification/tb_ctrl_regfile.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_ctrl_regfile
FILELIST   := vlog.f
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
